// File: hdl/sdram_cmd_pkg.sv
////////////////////////////////////////
// SDRAM command codes, fixed timing
// counts, mode word and pin bundle
////////////////////////////////////////

package sdram_cmd_pkg;

    // {cs_n, ras_n, cas_n, we_n}
    typedef enum logic [3:0] {
        LOAD_MODE = 4'b0000,
        REFRESH   = 4'b0001,
        PRECHARGE = 4'b0010,
        ACTIVE    = 4'b0011,
        WRITE     = 4'b0100,
        READ      = 4'b0101,
        NOP       = 4'b0111
    } sdram_cmd_e;

    // everything that leaves the chip on a clock edge
    typedef struct packed {
        sdram_cmd_e  cmd;
        logic        ba;    // two banks only
        logic [12:0] a;
        logic [1:0]  dqm;   // {high, low} byte
    } sdram_pins_t;

    // cycle counts at the target clock
    localparam int T_RCD   = 2;  // activate to read/write
    localparam int CAS_LAT = 2;
    localparam int T_RP    = 2;  // precharge period
    localparam int T_RFC   = 7;  // refresh to next command

    // reserved, write burst mode, op mode, CAS latency, burst type, burst length
    localparam logic [12:0] MODE_WORD = {
        3'b000,
        1'b0,
        2'b00,
        3'b010,   // CAS 2
        1'b0,     // sequential
        3'b000    // burst of one word
    };

endpackage

// File: hdl/sdram_req_pkg.sv
////////////////////////////////////////
// port-side word, mask, row and column
// types, request, read response and
// engine command structs
////////////////////////////////////////

package sdram_req_pkg;

    import sdram_cmd_pkg::*;

    typedef logic [15:0] word_t;
    typedef logic [1:0]  mask_t;   // a set bit blocks that byte
    typedef logic [12:0] row_t;
    typedef logic [8:0]  col_t;

    typedef struct packed {
        logic  we;
        row_t  row;
        col_t  col;
        word_t data;
        mask_t mask;
    } mem_req_t;

    typedef struct packed {
        logic  valid;
        word_t data;
    } rd_resp_t;

    // what an engine offers to the arbiter
    typedef struct packed {
        sdram_cmd_e  cmd;
        logic [12:0] a;
        mask_t       dqm;
        word_t       wdata;
    } bank_cmd_t;

endpackage

// File: hdl/sdram_bank_ctl.sv
////////////////////////////////////////
// bank engine with a credit-sized
// request queue and the activate,
// read/write and recovery FSM
////////////////////////////////////////

`timescale 1ns/1ps

module sdram_bank_ctl
    import sdram_cmd_pkg::*, sdram_req_pkg::*;
#(
    parameter int BANK_ID = 0,
    parameter int CREDITS = 2
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      req_valid,
    input  mem_req_t  req,
    output logic      credit_ret,
    output logic      br,
    output bank_cmd_t bank_cmd,
    input  logic      bg,
    output logic      idle
);

    localparam int PTR_W = (CREDITS > 1) ? $clog2(CREDITS) : 1;
    localparam int CNT_W = $clog2(CREDITS + 1);

    typedef enum logic [2:0] {IDLE, ACT, TRCD, RW, RECOV} bank_state_e;

    bank_state_e      state;
    mem_req_t         queue [CREDITS];
    mem_req_t         head;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;     // queued entries
    logic [2:0]       cnt;       // tRCD / tRP countdown
    logic             pop;

    assign head = queue[rd_ptr];
    assign pop  = (state == RW) && bg;   // entry leaves with its read/write
    assign br   = (state == ACT) || (state == RW);

    // at rest means no row open or closing in this bank
    // a head entry still waiting for its ACTIVE counts as at rest,
    // so a pending refresh can start while requests are queued
    assign idle = (state == IDLE) || (state == ACT);

    always_comb begin
        bank_cmd.cmd   = NOP;
        bank_cmd.a     = '0;
        bank_cmd.dqm   = '0;
        bank_cmd.wdata = head.data;
        case (state)
            ACT: begin
                bank_cmd.cmd = ACTIVE;
                bank_cmd.a   = head.row;
            end
            RW: begin
                bank_cmd.cmd = head.we ? WRITE : READ;
                bank_cmd.a   = {2'b00, 1'b1, 1'b0, head.col};  // a10 for auto-precharge
                bank_cmd.dqm = head.we ? head.mask : 2'b00;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            queue[wr_ptr] <= req;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= IDLE;
            cnt        <= '0;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credit_ret <= 1'b0;
        end else begin
            credit_ret <= pop;
            if (req_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(req_valid) - CNT_W'(pop);

            case (state)
                IDLE: begin
                    if (count != '0) begin
                        state <= ACT;
                    end
                end
                ACT: begin
                    if (bg) begin
                        state <= TRCD;
                        cnt   <= 3'(T_RCD - 2);  // the grant cycle itself counts once
                    end
                end
                TRCD: begin
                    if (cnt == '0) begin
                        state <= RW;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                RW: begin
                    if (bg) begin
                        state <= RECOV;
                        cnt   <= 3'(T_RP - 1);
                    end
                end
                RECOV: begin
                    if (cnt == '0) begin
                        state <= IDLE;   // auto-precharge done
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // requester keeps its own credit count
    a_no_push_full: assert property (
        @(posedge clk) disable iff (rst)
        req_valid |-> count < CNT_W'(CREDITS)
    ) else $error("bank %0d: request while queue full", BANK_ID);

    a_br_has_entry: assert property (
        @(posedge clk) disable iff (rst)
        br |-> count != '0
    ) else $error("bank %0d: bus request with empty queue", BANK_ID);

endmodule

// File: hdl/sdram_cmd_arb.sv
////////////////////////////////////////
// command arbiter with init sequence,
// refresh scheduling, LFSR priority,
// pin registers and read-return pipe
////////////////////////////////////////

`timescale 1ns/1ps

module sdram_cmd_arb
    import sdram_cmd_pkg::*, sdram_req_pkg::*;
#(
    parameter int RFSH_CNT  = 2,
    parameter int INIT_WAIT = 10000
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [1:0]  br,
    input  bank_cmd_t   bank_cmd0,
    input  bank_cmd_t   bank_cmd1,
    input  logic [1:0]  idle,
    output logic [1:0]  bg,
    input  logic        rfsh,
    output logic        init,
    output sdram_pins_t sdram_pins,
    inout  wire word_t  sdram_dq,
    output rd_resp_t    rd_resp0,
    output rd_resp_t    rd_resp1
);

    localparam int TMR_W = $clog2(INIT_WAIT + T_RFC + 1);
    localparam int RC_W  = $clog2(RFSH_CNT + 3);

    typedef enum logic [2:0] {WAIT, PRECH, IRFSH, MODE, RUN, RFSH} arb_state_e;

    arb_state_e       state;
    logic [TMR_W-1:0] tmr;
    logic [RC_W-1:0]  rcnt;        // refresh commands still to issue
    logic             rfsh_pend;
    logic             rfsh_go;
    logic [14:0]      lfsr;
    logic [1:0]       elig;
    logic             dq_busy;
    bank_cmd_t        gcmd;
    sdram_pins_t      nxt_pins;
    logic             issue_rd;
    logic             issue_wr;
    logic             dq_oe;
    word_t            dq_out;
    logic [CAS_LAT:0] pipe_vld;    // stage 0 lines up with READ on the pins
    logic [CAS_LAT:0] pipe_bank;
    logic [1:0]       resp_vld;
    word_t            resp_data;

    assign init    = (state != RUN) && (state != RFSH);
    assign rfsh_go = (state == RUN) && rfsh_pend && (&idle);
    assign dq_busy = |pipe_vld[CAS_LAT-1:0];  // read data about to use dq

    // a pending refresh holds back activations only, so open rows can close
    always_comb begin
        elig[0] = br[0] && !(rfsh_pend && bank_cmd0.cmd == ACTIVE)
                        && !(dq_busy && bank_cmd0.cmd == WRITE);
        elig[1] = br[1] && !(rfsh_pend && bank_cmd1.cmd == ACTIVE)
                        && !(dq_busy && bank_cmd1.cmd == WRITE);
        bg = 2'b00;
        if (state == RUN) begin
            case (elig)
                2'b01:   bg = 2'b01;
                2'b10:   bg = 2'b10;
                2'b11:   bg = lfsr[0] ? 2'b10 : 2'b01;
                default: bg = 2'b00;
            endcase
        end
    end

    always_comb begin
        gcmd     = bg[1] ? bank_cmd1 : bank_cmd0;
        nxt_pins = '{cmd: NOP, ba: 1'b0, a: '0, dqm: '0};
        case (state)
            PRECH: begin
                nxt_pins.cmd   = PRECHARGE;
                nxt_pins.a[10] = 1'b1;   // all banks
            end
            IRFSH, RFSH: begin
                if (tmr == '0 && rcnt != '0) begin
                    nxt_pins.cmd = REFRESH;
                end
            end
            MODE: begin
                nxt_pins.cmd = LOAD_MODE;
                nxt_pins.a   = MODE_WORD;
            end
            RUN: begin
                if (|bg) begin
                    nxt_pins.cmd = gcmd.cmd;
                    nxt_pins.ba  = bg[1];
                    nxt_pins.a   = gcmd.a;
                    nxt_pins.dqm = gcmd.dqm;
                end
            end
            default: ;
        endcase
        issue_rd = (|bg) && (gcmd.cmd == READ);
        issue_wr = (|bg) && (gcmd.cmd == WRITE);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= WAIT;
            tmr       <= TMR_W'(INIT_WAIT - 1);
            rcnt      <= '0;
            rfsh_pend <= 1'b0;
        end else begin
            rfsh_pend <= rfsh | (rfsh_pend & ~rfsh_go);
            case (state)
                WAIT: begin
                    if (tmr == '0) begin
                        state <= PRECH;
                    end else begin
                        tmr <= tmr - 1'b1;
                    end
                end
                PRECH: begin
                    state <= IRFSH;
                    tmr   <= TMR_W'(T_RP - 1);
                    rcnt  <= RC_W'(2);
                end
                IRFSH, RFSH: begin
                    if (tmr != '0) begin
                        tmr <= tmr - 1'b1;
                    end else if (rcnt != '0) begin
                        rcnt <= rcnt - 1'b1;
                        tmr  <= TMR_W'(T_RFC - 1);
                    end else begin
                        state <= (state == IRFSH) ? MODE : RUN;
                    end
                end
                MODE: state <= RUN;
                RUN: begin
                    if (rfsh_go) begin
                        state <= RFSH;
                        tmr   <= '0;
                        rcnt  <= RC_W'(RFSH_CNT);
                    end
                end
                default: state <= WAIT;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr       <= 15'd1;
            sdram_pins <= '{cmd: NOP, ba: 1'b0, a: '0, dqm: '0};
            dq_oe      <= 1'b0;
            pipe_vld   <= '0;
            resp_vld   <= 2'b00;
        end else begin
            lfsr       <= {lfsr[13:0], lfsr[14] ^ lfsr[13]};  // x^15 + x^14 + 1
            sdram_pins <= nxt_pins;
            dq_oe      <= issue_wr;
            pipe_vld   <= {pipe_vld[CAS_LAT-1:0], issue_rd};
            resp_vld[0] <= pipe_vld[CAS_LAT] & ~pipe_bank[CAS_LAT];
            resp_vld[1] <= pipe_vld[CAS_LAT] & pipe_bank[CAS_LAT];
        end
    end

    always_ff @(posedge clk) begin
        dq_out    <= gcmd.wdata;
        pipe_bank <= {pipe_bank[CAS_LAT-1:0], bg[1]};
        resp_data <= sdram_dq;   // only meaningful at the end of the pipe
    end

    assign sdram_dq = dq_oe ? dq_out : 'z;
    assign rd_resp0 = '{valid: resp_vld[0], data: resp_data};
    assign rd_resp1 = '{valid: resp_vld[1], data: resp_data};

    a_bg_onehot: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(bg)
    ) else $error("arbiter granted both banks");

    a_grant_run: assert property (
        @(posedge clk) disable iff (rst)
        (|bg) |-> (state == RUN)
    ) else $error("grant outside of normal operation");

endmodule

// File: hdl/sdram_ctrl_top.sv
////////////////////////////////////////
// two-port SDRAM controller top, two
// bank engines and the arbiter
////////////////////////////////////////

`timescale 1ns/1ps

module sdram_ctrl_top
    import sdram_cmd_pkg::*, sdram_req_pkg::*;
#(
    parameter int CREDITS   = 2,
    parameter int RFSH_CNT  = 2,
    parameter int INIT_WAIT = 10000
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [1:0]  req_valid,
    input  mem_req_t    req0,
    input  mem_req_t    req1,
    output logic [1:0]  credit_ret,
    output rd_resp_t    rd_resp0,
    output rd_resp_t    rd_resp1,
    input  logic        rfsh,
    output logic        init,
    output sdram_pins_t sdram_pins,
    inout  wire word_t  sdram_dq
);

    logic [1:0] br;
    logic [1:0] bg;
    logic [1:0] idle;
    bank_cmd_t  bank_cmd0;
    bank_cmd_t  bank_cmd1;

    sdram_bank_ctl #(.BANK_ID(0), .CREDITS(CREDITS)) u_bank0 (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid[0]),
        .req        (req0),
        .credit_ret (credit_ret[0]),
        .br         (br[0]),
        .bank_cmd   (bank_cmd0),
        .bg         (bg[0]),
        .idle       (idle[0])
    );

    sdram_bank_ctl #(.BANK_ID(1), .CREDITS(CREDITS)) u_bank1 (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid[1]),
        .req        (req1),
        .credit_ret (credit_ret[1]),
        .br         (br[1]),
        .bank_cmd   (bank_cmd1),
        .bg         (bg[1]),
        .idle       (idle[1])
    );

    sdram_cmd_arb #(.RFSH_CNT(RFSH_CNT), .INIT_WAIT(INIT_WAIT)) u_arb (
        .clk        (clk),
        .rst        (rst),
        .br         (br),
        .bank_cmd0  (bank_cmd0),
        .bank_cmd1  (bank_cmd1),
        .idle       (idle),
        .bg         (bg),
        .rfsh       (rfsh),
        .init       (init),
        .sdram_pins (sdram_pins),
        .sdram_dq   (sdram_dq),
        .rd_resp0   (rd_resp0),
        .rd_resp1   (rd_resp1)
    );

endmodule

// File: testbench/sdram_model.sv
////////////////////////////////////////
// behavioural two-bank SDRAM, sparse
// memory, CAS 2 reads, protocol checks
////////////////////////////////////////

`timescale 1ns/1ps

module sdram_model
    import sdram_cmd_pkg::*;
(
    input  logic        clk,
    input  sdram_pins_t pins,
    inout  wire  [15:0] dq,
    output int          proto_errs
);

    logic [15:0] mem [logic [22:0]];   // {bank, row, col}
    logic [12:0] open_row [2];
    logic        row_open [2];
    int          init_step;            // 0 prech, 1-2 refresh, 3 mode, 4 done
    logic        rd_vld1 = 1'b0;
    logic [15:0] rd_data1;
    logic        out_vld = 1'b0;
    logic [15:0] out_data;

    assign dq = out_vld ? out_data : 'z;

    initial begin
        proto_errs  = 0;
        init_step   = 0;
        row_open[0] = 1'b0;
        row_open[1] = 1'b0;
    end

    task automatic report(input string msg);
        $display("model protocol error at %0t: %s", $time, msg);
        proto_errs++;
    endtask

    always @(posedge clk) begin
        logic [22:0] key;
        logic [15:0] old;
        key      = {pins.ba, open_row[pins.ba], pins.a[8:0]};
        old      = mem.exists(key) ? mem[key] : 16'h0000;
        out_vld  <= rd_vld1;   // data sits on dq one cycle before the DUT samples it
        out_data <= rd_data1;
        rd_vld1  <= 1'b0;
        case (pins.cmd)
            PRECHARGE: begin
                if (init_step == 0 && pins.a[10]) init_step = 1;
                if (pins.a[10]) begin
                    row_open[0] = 1'b0;
                    row_open[1] = 1'b0;
                end else begin
                    row_open[pins.ba] = 1'b0;
                end
            end
            REFRESH: begin
                if (row_open[0] || row_open[1]) report("refresh while a row is open");
                if (init_step == 1 || init_step == 2) init_step++;
            end
            LOAD_MODE: begin
                if (init_step != 3) report("mode register loaded out of order");
                else if (pins.a != MODE_WORD) report("wrong mode register value");
                init_step = 4;
            end
            ACTIVE: begin
                if (init_step != 4) report("activate before the init sequence finished");
                if (row_open[pins.ba]) report("activate on a bank with an open row");
                row_open[pins.ba] = 1'b1;
                open_row[pins.ba] = pins.a;
            end
            READ, WRITE: begin
                if (!row_open[pins.ba]) report("read or write with no open row");
                if (pins.cmd == READ) begin
                    rd_vld1  <= 1'b1;
                    rd_data1 <= old;
                end else begin
                    mem[key] = {pins.dqm[1] ? old[15:8] : dq[15:8],
                                pins.dqm[0] ? old[7:0] : dq[7:0]};
                end
                if (pins.a[10]) row_open[pins.ba] = 1'b0;  // auto-precharge
            end
            default: ;
        endcase
    end

endmodule

// File: testbench/sdram_checker.sv
////////////////////////////////////////
// compares read data, credit counts and
// refresh commands with the tests file
////////////////////////////////////////

`timescale 1ns/1ps

module sdram_checker
    import sdram_cmd_pkg::*, sdram_req_pkg::*;
#(
    parameter int CREDITS  = 2,
    parameter int RFSH_CNT = 2
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [1:0]  req_valid,
    input  logic [1:0]  credit_ret,
    input  rd_resp_t    rd_resp0,
    input  rd_resp_t    rd_resp1,
    input  sdram_pins_t pins,
    input  logic        init,
    input  int          proto_errs,
    output logic        done,
    output int          errors
);

    logic  t_we  [2][$];
    word_t t_exp [2][$];
    int    t_num [2][$];
    int    n_rd [2], got_rd [2], rd_ptr [2], cred_ptr [2], outstanding [2];
    int    n_rf, rfsh_seen, passed, failed;

    initial begin
        int fd, n, line_no;
        string line;
        logic [7:0] tag, op;
        logic [15:0] row, col, data, mask, expv;
        errors    = 0;
        passed    = 0;
        failed    = 0;
        n_rf      = 0;
        rfsh_seen = 0;
        line_no   = 0;
        for (int p = 0; p < 2; p++) begin
            n_rd[p]        = 0;
            got_rd[p]      = 0;
            rd_ptr[p]      = 0;
            cred_ptr[p]    = 0;
            outstanding[p] = 0;
        end
        fd = $fopen("testbench/sdram_tests.txt", "r");
        if (fd == 0) $display("checker could not open the tests file");
        while (fd != 0 && !$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line[0] != "#") begin
                n = $sscanf(line, "%s %s %h %h %h %h %h", tag, op, row, col, data, mask, expv);
                if (n == 7 && tag == "R") n_rf++;
                else if (n == 7) begin
                    line_no++;
                    t_we[tag == "1"].push_back(op == "W");
                    t_exp[tag == "1"].push_back(expv);
                    t_num[tag == "1"].push_back(line_no);
                    if (op != "W") n_rd[tag == "1"]++;
                end
            end
        end
        if (fd != 0) $fclose(fd);
        if (line_no == 0) begin
            $display("no tests were loaded from the tests file");
            errors++;
        end
    end

    assign done = (cred_ptr[0] == t_we[0].size()) && (cred_ptr[1] == t_we[1].size())
               && (got_rd[0] == n_rd[0]) && (got_rd[1] == n_rd[1]);

    always @(posedge clk) begin
        rd_resp_t resp;
        logic     rw_cmd;
        if (!rst) begin
            if (!init && pins.cmd == REFRESH) rfsh_seen++;
            for (int p = 0; p < 2; p++) begin
                resp   = (p == 1) ? rd_resp1 : rd_resp0;
                // queue slot leaves with its read or write on the pins
                rw_cmd = (pins.cmd == READ || pins.cmd == WRITE) && (int'(pins.ba) == p);
                outstanding[p] += int'(req_valid[p]) - int'(rw_cmd);
                if (outstanding[p] > CREDITS || outstanding[p] < 0) begin
                    $display("[ERROR] %0t port %0d has %0d requests outstanding",
                             $time, p, outstanding[p]);
                    errors++;
                end
                if (credit_ret[p] !== rw_cmd) begin
                    $display("[ERROR] %0t port %0d credit_ret %b, read or write on pins %b",
                             $time, p, credit_ret[p], rw_cmd);
                    errors++;
                end
                if (credit_ret[p]) begin
                    if (cred_ptr[p] < t_we[p].size() && t_we[p][cred_ptr[p]]) begin
                        $display("test %0d port %0d write done", t_num[p][cred_ptr[p]], p);
                        passed++;
                    end
                    cred_ptr[p]++;
                end
                if (resp.valid) begin
                    while (rd_ptr[p] < t_we[p].size() && t_we[p][rd_ptr[p]]) rd_ptr[p]++;
                    if (rd_ptr[p] >= t_we[p].size()) begin
                        $display("[ERROR] %0t port %0d returned an unexpected read", $time, p);
                        errors++;
                    end else if (resp.data !== t_exp[p][rd_ptr[p]]) begin
                        $display("[ERROR] %0t test %0d port %0d read %h, expected %h",
                                 $time, t_num[p][rd_ptr[p]], p, resp.data,
                                 t_exp[p][rd_ptr[p]]);
                        errors++;
                        failed++;
                    end else begin
                        $display("test %0d port %0d read %h ok", t_num[p][rd_ptr[p]], p,
                                 resp.data);
                        passed++;
                    end
                    rd_ptr[p]++;
                    got_rd[p]++;
                end
            end
        end
    end

    task automatic finish_checks();
        if (rfsh_seen != RFSH_CNT * n_rf) begin
            $display("[ERROR] %0t saw %0d refresh commands, expected %0d",
                     $time, rfsh_seen, RFSH_CNT * n_rf);
            errors++;
        end
        for (int p = 0; p < 2; p++) begin
            if (cred_ptr[p] != t_we[p].size())
                $display("port %0d still has requests without a returned credit", p);
            if (cred_ptr[p] != t_we[p].size()) errors++;
        end
        errors += proto_errs;
    endtask

    task automatic print_counts();
        $display("tests passed %0d, failed %0d, errors %0d, protocol errors %0d",
                 passed, failed, errors, proto_errs);
    endtask

endmodule

// File: testbench/tb_sdram_ctrl.sv
////////////////////////////////////////
// testbench top: clock, reset, stimulus
// from the tests file, timeout, DUT
////////////////////////////////////////

`timescale 1ns/1ps

module tb_sdram_ctrl
    import sdram_cmd_pkg::*, sdram_req_pkg::*;
;

    localparam int CREDITS   = 2;
    localparam int RFSH_CNT  = 2;
    localparam int INIT_WAIT = 20;
    localparam int MAX_T     = 64;

    logic        clk = 1'b0;
    logic        rst, rfsh, valid0, valid1;
    mem_req_t    req0, req1;
    logic [1:0]  credit_ret;
    rd_resp_t    rd_resp0, rd_resp1;
    logic        init, chk_done;
    sdram_pins_t pins;
    wire  word_t dq;
    int          proto_errs, errors;

    mem_req_t    t_req [MAX_T];
    int          t_port [MAX_T];
    int          t_rf [MAX_T];       // rfsh pulses that come before this test
    int          n_tests = 0;
    int          n_rf = 0;
    int          issued [2];
    int          returned [2];
    int          port_rf [2];
    int          rf_sent, cycles;
    logic [31:0] lfsr_state;

    always #4 clk = ~clk;

    sdram_ctrl_top #(.CREDITS(CREDITS), .RFSH_CNT(RFSH_CNT), .INIT_WAIT(INIT_WAIT)) dut0 (
        .clk(clk), .rst(rst), .req_valid({valid1, valid0}), .req0(req0), .req1(req1),
        .credit_ret(credit_ret), .rd_resp0(rd_resp0), .rd_resp1(rd_resp1),
        .rfsh(rfsh), .init(init), .sdram_pins(pins), .sdram_dq(dq)
    );

    sdram_model model0 (.clk(clk), .pins(pins), .dq(dq), .proto_errs(proto_errs));

    sdram_checker #(.CREDITS(CREDITS), .RFSH_CNT(RFSH_CNT)) chk0 (
        .clk(clk), .rst(rst), .req_valid({valid1, valid0}), .credit_ret(credit_ret),
        .rd_resp0(rd_resp0), .rd_resp1(rd_resp1), .pins(pins), .init(init),
        .proto_errs(proto_errs), .done(chk_done), .errors(errors)
    );

    function automatic logic rand_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) lfsr_state = lfsr_state ^ 32'h8020_0003;
        return b;
    endfunction

    task automatic load_tests();
        int fd, n;
        string line;
        logic [7:0] tag, op;
        logic [15:0] row, col, data, mask, expv;
        fd = $fopen("testbench/sdram_tests.txt", "r");
        if (fd == 0) $display("could not open the tests file");
        while (fd != 0 && !$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line[0] != "#") begin
                n = $sscanf(line, "%s %s %h %h %h %h %h", tag, op, row, col, data, mask, expv);
                if (n == 7 && tag == "R") n_rf++;
                else if (n == 7 && n_tests < MAX_T) begin
                    t_req[n_tests] = '{we: (op == "W"), row: row[12:0], col: col[8:0],
                                       data: data, mask: mask[1:0]};
                    t_port[n_tests] = (tag == "1") ? 1 : 0;
                    t_rf[n_tests]   = n_rf;
                    n_tests++;
                end
            end
        end
        if (fd != 0) $fclose(fd);
    endtask

    task automatic run_port(input int p);
        int gap;
        for (int i = 0; i < n_tests; i++) begin
            if (t_port[i] == p) begin
                port_rf[p] = t_rf[i];
                while (rf_sent < t_rf[i]) @(negedge clk);
                gap = int'(rand_bit());
                gap = gap * 2 + int'(rand_bit());
                repeat (gap) @(negedge clk);
                while (CREDITS - (issued[p] - returned[p]) == 0) @(negedge clk);
                if (p == 0) begin
                    req0   = t_req[i];
                    valid0 = 1'b1;
                end else begin
                    req1   = t_req[i];
                    valid1 = 1'b1;
                end
                issued[p]++;
                @(negedge clk);
                if (p == 0) valid0 = 1'b0;
                else valid1 = 1'b0;
            end
        end
        port_rf[p] = MAX_T;
    endtask

    task automatic pulse_refreshes();
        for (int k = 0; k < n_rf; k++) begin
            while (port_rf[0] <= k || port_rf[1] <= k) @(negedge clk);
            rfsh = 1'b1;
            @(negedge clk);
            rfsh = 1'b0;
            rf_sent++;
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (credit_ret[0]) returned[0]++;
            if (credit_ret[1]) returned[1]++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > INIT_WAIT + 200 + 40 * (n_tests + n_rf)) begin
            $display("run timed out with tests still pending");
            chk0.print_counts();
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        rst = 1'b1; rfsh = 1'b0; valid0 = 1'b0; valid1 = 1'b0;
        req0 = '0; req1 = '0;
        cycles = 0; rf_sent = 0; lfsr_state = 32'h7310;
        issued[0] = 0; issued[1] = 0; returned[0] = 0; returned[1] = 0;
        port_rf[0] = 0; port_rf[1] = 0;
        load_tests();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        while (init) @(negedge clk);   // no requests during init
        fork
            run_port(0);
            run_port(1);
            pulse_refreshes();
        join
        while (!chk_done) @(negedge clk);
        repeat (4) @(negedge clk);
        chk0.finish_checks();
        @(negedge clk);
        chk0.print_counts();
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: compile.f
hdl/sdram_cmd_pkg.sv
hdl/sdram_req_pkg.sv
hdl/sdram_bank_ctl.sv
hdl/sdram_cmd_arb.sv
hdl/sdram_ctrl_top.sv
testbench/sdram_model.sv
testbench/sdram_checker.sv
testbench/tb_sdram_ctrl.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_sdram_ctrl
FLIST     = compile.f
PASS_MSG  = PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: testbench/sdram_tests.txt
# port (0, 1, or R for an rfsh pulse)  op (W write, D read)  row col data mask expect
# numbers in hex; a set mask bit blocks that byte; expect is used by reads only
0 W 0010 005 a5a5 0 0000
1 W 0010 005 5a5a 0 0000
0 D 0010 005 0000 0 a5a5
1 D 0010 005 0000 0 5a5a
0 W 0123 01f beef 0 0000
0 W 0123 01f 1234 2 0000
1 W 1fff 1ff ffff 0 0000
1 W 1fff 1ff 0000 1 0000
0 D 0123 01f 0000 0 be34
1 D 1fff 1ff 0000 0 00ff
R - 0000 000 0000 0 0000
0 D 0010 005 0000 0 a5a5
1 D 0010 005 0000 0 5a5a
0 W 0002 100 cafe 0 0000
1 W 0002 100 f00d 0 0000
0 D 0002 100 0000 0 cafe
1 D 0002 100 0000 0 f00d
R - 0000 000 0000 0 0000
0 D 0123 01f 0000 0 be34
1 D 1fff 1ff 0000 0 00ff
